// ==== source/wb_macros.svh ====
/*
 * Writeback stage sizing macros
 * Data width, queue depth, producer credits, CSR addresses, mtvec reset
 */
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

`define WB_XLEN          32                 // Data path width
`define WB_QUEUE_DEPTH   2                  // Writeback queue entries
`define WB_CREDITS       `WB_QUEUE_DEPTH    // Producer credits after reset

`define WB_CSR_MSCRATCH  12'h340
`define WB_CSR_MEPC      12'h341
`define WB_CSR_MCAUSE    12'h342
`define WB_CSR_MTVEC     12'h305
`define WB_MTVEC_RESET   32'h0000_0100      // Trap vector out of reset

`endif

// ==== source/wb_pipe_pkg.sv ====
/*
 * Pipeline item types for the writeback stage
 * Functional unit and micro-op enums, queue item, register write
 */
`include "wb_macros.svh"

package wb_pipe_pkg;

    typedef enum logic [2:0] {
        FU_ALU,
        FU_MUL,
        FU_LSU,
        FU_CFU,
        FU_CSR
    } fu_e;

    // Grouped by unit, 8 codes per group
    typedef enum logic [4:0] {
        UOP_NOP    = 5'h00,                  // ALU and MUL
        UOP_LB     = 5'h08, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU,
        UOP_SB, UOP_SH, UOP_SW,
        UOP_TAKEN  = 5'h10, UOP_JALI, UOP_JALR, UOP_NOT_TAKEN,
        UOP_ECALL, UOP_EBREAK, UOP_MRET,
        UOP_CSRRW  = 5'h18, UOP_CSRRS, UOP_CSRRC
    } uop_e;

    typedef struct packed {
        fu_e                  fu;
        uop_e                 uop;
        logic [4:0]           rd;
        logic [`WB_XLEN-1:0]  opr_a;         // Result, jump target or CSR data
        logic [`WB_XLEN-1:0]  opr_b;         // Memory or CSR address
        logic [`WB_XLEN-1:0]  pc;
        logic [`WB_XLEN-1:0]  next_pc;       // Link value
    } wb_item_t;

    typedef struct packed {
        logic                 en;
        logic [4:0]           rd;
        logic [`WB_XLEN-1:0]  data;
    } gpr_wr_t;

endpackage

// ==== source/wb_sys_pkg.sv ====
/*
 * Machine-mode system types
 * CSR access, trap causes, trap record, control-flow request
 */
`include "wb_macros.svh"

package wb_sys_pkg;

    typedef struct packed {
        logic                 en;
        logic                 rd;            // Read value wanted
        logic                 wr;
        logic                 set;
        logic                 clr;
        logic [11:0]          addr;
        logic [`WB_XLEN-1:0]  wdata;
    } csr_op_t;

    typedef enum logic [5:0] {
        TRAP_BREAKPT  = 6'd3,
        TRAP_LDACCESS = 6'd5,
        TRAP_STACCESS = 6'd7,
        TRAP_ECALLM   = 6'd11
    } trap_cause_e;

    typedef struct packed {
        logic                 take;
        trap_cause_e          cause;
        logic [`WB_XLEN-1:0]  pc;            // Goes to mepc
    } trap_t;

    typedef struct packed {
        logic                 req;
        logic [`WB_XLEN-1:0]  target;
    } cf_req_t;

endpackage

// ==== source/load_align.sv ====
/*
 * Load data alignment
 * Byte, halfword or word select with sign or zero extension
 */
`timescale 1ns/1ps
`include "wb_macros.svh"

module load_align import wb_pipe_pkg::*; (
    input  logic [`WB_XLEN-1:0] rdata,         // Raw bus word
    input  uop_e                uop,
    input  logic [1:0]          addr,          // Byte offset in the word
    output logic [`WB_XLEN-1:0] data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = rdata[{addr, 3'b000} +: 8];
    assign half_sel = addr[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (uop)
            UOP_LB:  data = {{24{byte_sel[7]}}, byte_sel};
            UOP_LBU: data = {24'b0, byte_sel};
            UOP_LH:  data = {{16{half_sel[15]}}, half_sel};
            UOP_LHU: data = {16'b0, half_sel};
            UOP_LW:  data = rdata;
            default: data = '0;                // Stores and non-LSU
        endcase
    end

    // Halfwords never straddle a half boundary
    always_comb begin
        if (uop == UOP_LH || uop == UOP_LHU) begin
            a_half_aligned: assert (!addr[0])
                else $error("misaligned halfword load");
        end
    end

endmodule

// ==== source/gpr_file.sv ====
/*
 * General purpose register file
 * x1..x31 writable, x0 reads zero, two async read ports
 */
`timescale 1ns/1ps
`include "wb_macros.svh"

module gpr_file import wb_pipe_pkg::*; (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  gpr_wr_t             wr,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output logic [`WB_XLEN-1:0] rs1_data,
    output logic [`WB_XLEN-1:0] rs2_data
);

    logic [`WB_XLEN-1:0] regs [1:31];          // No storage for x0

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.rd != 5'd0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Reads see the old value in a write cycle
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== source/csr_unit.sv ====
/*
 * Machine-mode CSR file
 * mscratch, mepc, mcause, mtvec; read/write/set/clear and trap update
 */
`timescale 1ns/1ps
`include "wb_macros.svh"

module csr_unit import wb_sys_pkg::*; (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  csr_op_t             op,
    input  trap_t               trap,
    input  logic                mret_exec,
    output logic [`WB_XLEN-1:0] rdata,         // Value before the write
    output logic [`WB_XLEN-1:0] mepc,          // Also the MRET target
    output logic [`WB_XLEN-1:0] mtvec
);

    logic [`WB_XLEN-1:0] mscratch;
    logic [`WB_XLEN-1:0] mcause;
    logic [`WB_XLEN-1:0] cur_val;
    logic [`WB_XLEN-1:0] new_val;
    logic                wr_any;

    always_comb begin
        case (op.addr)
            `WB_CSR_MSCRATCH: cur_val = mscratch;
            `WB_CSR_MEPC:     cur_val = mepc;
            `WB_CSR_MCAUSE:   cur_val = mcause;
            `WB_CSR_MTVEC:    cur_val = mtvec;
            default:          cur_val = '0;    // Unknown reads zero
        endcase
    end

    assign rdata   = op.rd ? cur_val : '0;
    assign wr_any  = op.en && (op.wr || op.set || op.clr);
    assign new_val = op.wr  ? op.wdata :
                     op.set ? (cur_val | op.wdata) : (cur_val & ~op.wdata);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtvec    <= `WB_MTVEC_RESET;
        end else if (trap.take) begin
            mepc   <= trap.pc;
            mcause <= {{(`WB_XLEN-6){1'b0}}, trap.cause};  // Sync cause, bit 31 clear
        end else if (wr_any) begin
            case (op.addr)
                `WB_CSR_MSCRATCH: mscratch <= new_val;
                `WB_CSR_MEPC:     mepc     <= new_val;
                `WB_CSR_MCAUSE:   mcause   <= new_val;
                `WB_CSR_MTVEC:    mtvec    <= new_val;
                default:          ;
            endcase
        end
    end

    // MRET lands on a word-aligned instruction
    a_mret_aligned: assert property (@(posedge g_clk) disable iff (!g_resetn)
        mret_exec |-> mepc[1:0] == 2'b00);

endmodule

// ==== source/wb_ctrl.sv ====
/*
 * Writeback controller
 * Credit-fed input queue, in-order retire, handshake sequencing,
 * result select, trap cause and credit return
 */
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_ctrl import wb_pipe_pkg::*, wb_sys_pkg::*; (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                item_valid,
    input  wb_item_t            item,
    input  logic                dmem_recv,
    input  logic                dmem_error,
    input  logic [`WB_XLEN-1:0] dmem_rdata,
    input  logic                cf_ack,
    input  logic [`WB_XLEN-1:0] load_data,     // Aligned load result
    input  logic [`WB_XLEN-1:0] csr_rdata,
    input  logic [`WB_XLEN-1:0] mepc,
    input  logic [`WB_XLEN-1:0] mtvec,
    output logic                credit_return,
    output logic                dmem_ack,
    output cf_req_t             cf,
    output gpr_wr_t             gpr_wr,
    output csr_op_t             csr_op,
    output trap_t               trap,
    output logic                mret_exec,
    output logic [`WB_XLEN-1:0] load_rdata,
    output uop_e                load_uop,
    output logic [1:0]          load_addr
);

    localparam int unsigned      DEPTH    = `WB_QUEUE_DEPTH;
    localparam int unsigned      PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned      CNT_W    = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    wb_item_t         q_mem [DEPTH];
    wb_item_t         head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             head_valid;
    logic             retire;
    logic             rsp_seen;               // Head got its memory response
    logic             rsp_err;                // ...and it was a bus error
    logic             fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic             lsu_load, lsu_store, rsp_now, lsu_rsp, lsu_err;
    logic             cfu_jump, cfu_link, cfu_ecall, cfu_ebreak, cfu_mret;
    logic             trap_tgt, cf_needed, cf_done;

    // Queue --------------------
    assign head       = q_mem[rd_ptr];
    assign head_valid = (count != '0);

    always_ff @(posedge g_clk) begin
        if (item_valid) begin
            q_mem[wr_ptr] <= item;             // Tail takes the new item
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (item_valid) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(item_valid) - CNT_W'(retire);
        end
    end

    // Decode --------------------
    assign fu_alu     = head_valid && (head.fu == FU_ALU);
    assign fu_mul     = head_valid && (head.fu == FU_MUL);
    assign fu_lsu     = head_valid && (head.fu == FU_LSU);
    assign fu_cfu     = head_valid && (head.fu == FU_CFU);
    assign fu_csr     = head_valid && (head.fu == FU_CSR);
    assign lsu_load   = fu_lsu && (head.uop inside {UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU});
    assign lsu_store  = fu_lsu && (head.uop inside {UOP_SB, UOP_SH, UOP_SW});
    assign cfu_jump   = fu_cfu && (head.uop inside {UOP_TAKEN, UOP_JALI, UOP_JALR});
    assign cfu_link   = fu_cfu && (head.uop inside {UOP_JALI, UOP_JALR});
    assign cfu_ecall  = fu_cfu && (head.uop == UOP_ECALL);
    assign cfu_ebreak = fu_cfu && (head.uop == UOP_EBREAK);
    assign cfu_mret   = fu_cfu && (head.uop == UOP_MRET);

    // Handshakes --------------------
    assign dmem_ack  = fu_lsu && !rsp_seen;    // Loads and stores both wait
    assign rsp_now   = dmem_ack && dmem_recv;
    assign lsu_rsp   = rsp_now || rsp_seen;
    assign lsu_err   = (rsp_now && dmem_error) || (rsp_seen && rsp_err);
    assign trap_tgt  = cfu_ecall || cfu_ebreak || lsu_err;
    assign cf_needed = cfu_jump || cfu_mret || trap_tgt;
    assign cf_done   = cf.req && cf_ack;

    always_comb begin
        cf.req    = cf_needed;
        cf.target = cfu_jump ? head.opr_a :
                    cfu_mret ? mepc       : mtvec;  // Traps go to mtvec
    end

    // Bus error loads need the redirect too before leaving
    always_comb begin
        retire = head_valid;
        if (fu_lsu) begin
            retire = lsu_rsp && (!lsu_err || cf_done);
        end else if (cf_needed) begin
            retire = cf_done;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_seen      <= 1'b0;
            rsp_err       <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            rsp_seen      <= !retire && lsu_rsp;
            rsp_err       <= rsp_now ? dmem_error : (rsp_err && !retire);
            credit_return <= retire;           // One credit back per entry
        end
    end

    // Results --------------------
    always_comb begin
        csr_op.en    = fu_csr;
        csr_op.rd    = fu_csr;
        csr_op.wr    = fu_csr && (head.uop == UOP_CSRRW);
        csr_op.set   = fu_csr && (head.uop == UOP_CSRRS);
        csr_op.clr   = fu_csr && (head.uop == UOP_CSRRC);
        csr_op.addr  = head.opr_b[11:0];
        csr_op.wdata = head.opr_a;
    end

    assign load_rdata = rsp_now ? dmem_rdata : '0;
    assign load_uop   = fu_lsu ? head.uop : UOP_NOP;
    assign load_addr  = head.opr_b[1:0];

    always_comb begin
        gpr_wr.en = retire && (fu_alu || fu_mul || fu_csr || cfu_link ||
                               (lsu_load && !lsu_err));   // Error kills write
        gpr_wr.rd = head.rd;
        if (fu_lsu) begin
            gpr_wr.data = load_data;
        end else if (fu_csr) begin
            gpr_wr.data = csr_rdata;           // Old CSR value
        end else if (fu_cfu) begin
            gpr_wr.data = head.next_pc;
        end else begin
            gpr_wr.data = head.opr_a;
        end
    end

    always_comb begin
        trap.take  = retire && trap_tgt;
        trap.cause = lsu_err    ? (lsu_store ? TRAP_STACCESS : TRAP_LDACCESS) :
                     cfu_ebreak ? TRAP_BREAKPT : TRAP_ECALLM;
        trap.pc    = head.pc;
    end

    assign mret_exec = retire && cfu_mret;

    // Checks --------------------
    // Producer only sends with a credit in hand
    a_no_overflow: assert property (@(posedge g_clk) disable iff (!g_resetn)
        item_valid |-> count != CNT_FULL);

    a_cf_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf.req && !cf_ack |=> cf.req && $stable(cf.target));

endmodule

// ==== source/wb_top.sv ====
/*
 * Writeback stage top
 * Controller plus load align, register file and CSR file
 */
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_top import wb_pipe_pkg::*, wb_sys_pkg::*; (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                item_valid,
    input  wb_item_t            item,
    input  logic                dmem_recv,
    input  logic                dmem_error,
    input  logic [`WB_XLEN-1:0] dmem_rdata,
    input  logic                cf_ack,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output logic                credit_return,
    output logic                dmem_ack,
    output cf_req_t             cf,
    output gpr_wr_t             gpr_wr,
    output trap_t               trap,
    output logic [`WB_XLEN-1:0] rs1_data,
    output logic [`WB_XLEN-1:0] rs2_data
);

    csr_op_t             csr_op;
    logic                mret_exec;
    logic [`WB_XLEN-1:0] csr_rdata;
    logic [`WB_XLEN-1:0] mepc;
    logic [`WB_XLEN-1:0] mtvec;
    logic [`WB_XLEN-1:0] load_rdata;
    logic [`WB_XLEN-1:0] load_data;
    uop_e                load_uop;
    logic [1:0]          load_addr;

    wb_ctrl u_ctrl (.*);

    load_align u_align (
        .rdata (load_rdata),
        .uop   (load_uop),
        .addr  (load_addr),
        .data  (load_data)
    );

    gpr_file u_gpr (
        .g_clk, .g_resetn, .wr (gpr_wr), .rs1, .rs2, .rs1_data, .rs2_data
    );

    csr_unit u_csr (
        .g_clk, .g_resetn, .op (csr_op), .trap, .mret_exec,
        .rdata (csr_rdata), .mepc, .mtvec
    );

endmodule

// ==== bench/wb_tests.svh ====
/*
 * Directed tests for the writeback stage
 * ALU/MUL, loads and stores, control flow, CSR, traps, credit burst
 */

function automatic wb_item_t build_item(input fu_e fu, input uop_e uop,
        input logic [4:0] rd, input logic [31:0] a, input logic [31:0] b,
        input logic [31:0] pc, input logic [31:0] npc);
    return wb_item_t'{fu, uop, rd, a, b, pc, npc};
endfunction

// Shift the addressed lane down, then extend
function automatic logic [31:0] expected_load(input uop_e uop, input logic [31:0] word,
                                              input int off);
    logic [31:0] sh;
    sh = word >> (8 * off);
    case (uop)
        UOP_LB:  return {{24{sh[7]}}, sh[7:0]};
        UOP_LBU: return {24'h0, sh[7:0]};
        UOP_LH:  return {{16{sh[15]}}, sh[15:0]};
        UOP_LHU: return {16'h0, sh[15:0]};
        default: return word;
    endcase
endfunction

task automatic test_alu_mul();
    send_item(build_item(FU_ALU, UOP_NOP, 5'd5, 32'h1234_5678, 0, 32'h100, 32'h104));
    send_item(build_item(FU_MUL, UOP_NOP, 5'd6, 32'hdead_beef, 0, 32'h104, 32'h108));
    send_item(build_item(FU_ALU, UOP_NOP, 5'd0, 32'hffff_ffff, 0, 32'h108, 32'h10c));
    wait_idle();
    expect_write("alu", 5'd5, 32'h1234_5678);
    expect_write("mul", 5'd6, 32'hdead_beef);
    expect_write("alu x0", 5'd0, 32'hffff_ffff);  // Seen on the bus, not stored
    check_drained("alu_mul");
    read_regs("regfile", 5'd5, 32'h1234_5678, 5'd6, 32'hdead_beef);
    read_regs("regfile x0", 5'd0, 32'h0, 5'd5, 32'h1234_5678);
endtask

task automatic test_loads();
    uop_e        loads [5] = '{UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU};
    uop_e        stores [3] = '{UOP_SB, UOP_SH, UOP_SW};
    logic [31:0] words [2] = '{32'h80ff_7f01, 32'h7f80_01fe};  // Mixed sign bits
    logic [31:0] addr;
    foreach (words[w]) begin
        rsp_data = words[w];
        foreach (loads[u]) begin
            for (int off = 0; off < 4; off++) begin
                if (loads[u] == UOP_LW && off != 0)
                    continue;
                if ((loads[u] == UOP_LH || loads[u] == UOP_LHU) && (off % 2) != 0)
                    continue;                   // Halfwords stay aligned
                addr = 32'h2000 + 32'(off);
                send_item(build_item(FU_LSU, loads[u], 5'd9, 0, addr, 32'h400, 32'h404));
                wait_idle();
                expect_write($sformatf("%s offset %0d", loads[u].name(), off), 5'd9,
                             expected_load(loads[u], words[w], off));
            end
        end
    end
    foreach (stores[s])
        send_item(build_item(FU_LSU, stores[s], 5'd10, 32'h55, 32'h2004, 32'h408, 32'h40c));
    wait_idle();
    check_drained("loads and stores");        // Stores write nothing
endtask

task automatic test_control_flow();
    send_item(build_item(FU_CFU, UOP_TAKEN, 5'd0, 32'h400, 0, 32'h200, 32'h204));
    send_item(build_item(FU_CFU, UOP_JALI, 5'd1, 32'h800, 0, 32'h204, 32'h208));
    send_item(build_item(FU_CFU, UOP_JALR, 5'd2, 32'h900, 0, 32'h208, 32'h20c));
    send_item(build_item(FU_CFU, UOP_NOT_TAKEN, 5'd0, 32'h600, 0, 32'h20c, 32'h210));
    wait_idle();
    expect_redirect("taken", 32'h400);
    expect_redirect("jal", 32'h800);
    expect_write("jal link", 5'd1, 32'h208);
    expect_redirect("jalr", 32'h900);
    expect_write("jalr link", 5'd2, 32'h20c);
    check_drained("control flow");            // Not taken asks for nothing
endtask

task automatic test_csr();
    uop_e        ops [3] = '{UOP_CSRRW, UOP_CSRRS, UOP_CSRRC};
    logic [31:0] wdata [3] = '{32'ha5a5_0f0f, 32'h0000_00f0, 32'h0f00_000f};
    logic [31:0] model;
    model = 32'h0;                              // mscratch out of reset
    foreach (ops[i]) begin
        send_item(build_item(FU_CSR, ops[i], 5'(11 + i), wdata[i],
                             32'(`WB_CSR_MSCRATCH), 32'h500, 32'h504));
        wait_idle();
        expect_write(ops[i].name(), 5'(11 + i), model);  // Old value
        case (ops[i])
            UOP_CSRRW: model = wdata[i];
            UOP_CSRRS: model = model | wdata[i];
            default:   model = model & ~wdata[i];
        endcase
    end
    // Zero set mask reads without changing
    send_item(build_item(FU_CSR, UOP_CSRRS, 5'd14, 0, 32'(`WB_CSR_MSCRATCH), 32'h510, 0));
    send_item(build_item(FU_CSR, UOP_CSRRS, 5'd15, 0, 32'(`WB_CSR_MTVEC), 32'h514, 0));
    wait_idle();
    expect_write("mscratch readback", 5'd14, model);
    expect_write("mtvec readback", 5'd15, `WB_MTVEC_RESET);
    check_drained("csr");
endtask

task automatic run_bus_fault(input uop_e uop, input logic [31:0] pc,
                             input logic [5:0] cause);
    rsp_error = 1'b1;
    send_item(build_item(FU_LSU, uop, 5'd7, 32'h77, 32'h3000, pc, pc + 4));
    wait_idle();
    rsp_error = 1'b0;
    send_item(build_item(FU_CSR, UOP_CSRRS, 5'd8, 0, 32'(`WB_CSR_MEPC), pc + 4, 0));
    send_item(build_item(FU_CFU, UOP_MRET, 5'd0, 0, 0, pc + 8, 0));
    wait_idle();
    expect_redirect({uop.name(), " fault"}, `WB_MTVEC_RESET);
    expect_trap({uop.name(), " fault"}, cause, pc);
    expect_write("mepc readback", 5'd8, pc);
    expect_redirect("mret", pc);                // Back to the faulting PC
endtask

task automatic test_traps();
    send_item(build_item(FU_CFU, UOP_ECALL, 5'd0, 0, 0, 32'h300, 32'h304));
    send_item(build_item(FU_CFU, UOP_EBREAK, 5'd0, 0, 0, 32'h304, 32'h308));
    wait_idle();
    expect_redirect("ecall", `WB_MTVEC_RESET);
    expect_trap("ecall", 6'd11, 32'h300);
    expect_redirect("ebreak", `WB_MTVEC_RESET);
    expect_trap("ebreak", 6'd3, 32'h304);
    run_bus_fault(UOP_LW, 32'h310, 6'd5);
    run_bus_fault(UOP_SW, 32'h320, 6'd7);
    check_drained("traps");                   // Faulting load wrote nothing
endtask

task automatic test_credits();
    int base;
    base = returned;
    for (int i = 0; i < 12; i++)
        send_item(build_item(FU_ALU, UOP_NOP, 5'(16 + i), 32'(i * 7 + 1), 0, 32'h600, 0));
    wait_idle();
    repeat (4) @(negedge g_clk);                // Room for a stray pulse
    check_value("credit pulses", 32'd12, 32'(returned - base));
    for (int i = 0; i < 12; i++)
        expect_write("burst", 5'(16 + i), 32'(i * 7 + 1));
    check_drained("credits");
endtask

// ==== bench/wb_tb.sv ====
/*
 * Writeback stage testbench
 * Clock, reset, DUT, credit producer, memory and control-flow responder,
 * LFSR, write/redirect/trap monitor, result checks, watchdog and summary
 */
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_tb import wb_pipe_pkg::*, wb_sys_pkg::*; ();

    localparam int RESET_CYCLES   = 10;
    localparam int ITEM_BUDGET    = 80;         // More than the tests send
    localparam int WORST_CYCLES   = 16;         // Memory plus redirect delay, with slack
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + ITEM_BUDGET * WORST_CYCLES + 100;

    logic        g_clk = 1'b0;
    logic        g_resetn;
    logic        item_valid;
    wb_item_t    item;
    logic        dmem_recv;
    logic        dmem_error;
    logic [31:0] dmem_rdata;
    logic        cf_ack;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        credit_return;
    logic        dmem_ack;
    cf_req_t     cf;
    gpr_wr_t     gpr_wr;
    trap_t       trap;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    int          sent;                          // Items pushed by the producer
    int          returned;                      // Credit pulses seen
    int          errors;
    int          checks;
    logic [31:0] lfsr_state;
    logic [31:0] rsp_data;                      // Memory reply set up by a test
    logic        rsp_error;
    gpr_wr_t     wr_log [$];
    logic [31:0] cf_log [$];
    trap_t       trap_log [$];
    int          wr_idx;                        // Next log entry to check
    int          cf_idx;
    int          trap_idx;

    wb_top dut (.*);

    always #10 g_clk = ~g_clk;                  // 20 ns period

    // Random delays --------------------
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    // Bus responders --------------------
    task automatic serve_dmem();
        repeat (random_bits(2)) @(negedge g_clk);  // 0 to 3 cycles
        dmem_rdata = rsp_data;
        dmem_error = rsp_error;
        dmem_recv  = 1'b1;
        @(negedge g_clk);                       // Handshake took the edge in between
        dmem_recv  = 1'b0;
        dmem_error = 1'b0;
    endtask

    task automatic serve_cf();
        repeat (random_bits(2)) @(negedge g_clk);
        cf_ack = 1'b1;
        @(negedge g_clk);
        cf_ack = 1'b0;
    endtask

    // Only one head entry, so memory and redirect never overlap
    initial begin
        dmem_recv  = 1'b0;
        dmem_error = 1'b0;
        dmem_rdata = '0;
        cf_ack     = 1'b0;
        lfsr_state = 32'd90736;
        forever begin
            @(negedge g_clk);
            if (dmem_ack)
                serve_dmem();
            else if (cf.req)
                serve_cf();
        end
    end

    // Monitor --------------------
    always @(posedge g_clk) begin
        if (!g_resetn) begin
            returned = 0;
        end else begin
            if (gpr_wr.en)
                wr_log.push_back(gpr_wr);
            if (cf.req && cf_ack)
                cf_log.push_back(cf.target);   // Redirect accepted
            if (trap.take)
                trap_log.push_back(trap);
            if (credit_return)
                returned++;
        end
    end

    // Producer --------------------
    task automatic send_item(input wb_item_t it);
        while (sent - returned >= `WB_CREDITS)
            @(negedge g_clk);                   // No credit in hand
        item       = it;
        item_valid = 1'b1;
        sent++;
        @(negedge g_clk);
        item_valid = 1'b0;
    endtask

    task automatic wait_idle();
        do
            @(negedge g_clk);
        while (sent != returned);               // All credits back
    endtask

    // Checks --------------------
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Error in %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic expect_write(input string name, input logic [4:0] rd,
                                input logic [31:0] data);
        checks++;
        assert (wr_idx < wr_log.size()) else begin
            errors++;
            $display("%s: the register write to x%0d never happened", name, rd);
        end
        if (wr_idx < wr_log.size()) begin
            check_value({name, " rd"}, 32'(rd), 32'(wr_log[wr_idx].rd));
            check_value({name, " data"}, data, wr_log[wr_idx].data);
            wr_idx++;
        end
    endtask

    task automatic expect_redirect(input string name, input logic [31:0] target);
        checks++;
        assert (cf_idx < cf_log.size()) else begin
            errors++;
            $display("%s: no control-flow redirect was requested", name);
        end
        if (cf_idx < cf_log.size()) begin
            check_value({name, " target"}, target, cf_log[cf_idx]);
            cf_idx++;
        end
    endtask

    task automatic expect_trap(input string name, input logic [5:0] cause,
                               input logic [31:0] pc);
        checks++;
        assert (trap_idx < trap_log.size()) else begin
            errors++;
            $display("%s: no trap was raised", name);
        end
        if (trap_idx < trap_log.size()) begin
            check_value({name, " cause"}, 32'(cause), 32'(trap_log[trap_idx].cause));
            check_value({name, " pc"}, pc, trap_log[trap_idx].pc);
            trap_idx++;
        end
    endtask

    // Anything left over was not expected
    task automatic check_drained(input string name);
        checks++;
        assert (wr_idx == wr_log.size() && cf_idx == cf_log.size() &&
                trap_idx == trap_log.size()) else begin
            errors++;
            $display("%s: %0d extra register writes, %0d extra redirects, %0d extra traps",
                     name, wr_log.size() - wr_idx, cf_log.size() - cf_idx,
                     trap_log.size() - trap_idx);
            wr_idx   = wr_log.size();
            cf_idx   = cf_log.size();
            trap_idx = trap_log.size();
        end
    endtask

    task automatic read_regs(input string name, input logic [4:0] r1,
                             input logic [31:0] e1, input logic [4:0] r2,
                             input logic [31:0] e2);
        rs1 = r1;
        rs2 = r2;
        @(negedge g_clk);                       // Read ports settled
        check_value({name, " rs1"}, e1, rs1_data);
        check_value({name, " rs2"}, e2, rs2_data);
    endtask

    `include "wb_tests.svh"

    // Main sequence --------------------
    initial begin
        g_resetn   = 1'b0;
        item_valid = 1'b0;
        item       = '0;
        rs1        = '0;
        rs2        = '0;
        rsp_data   = '0;
        rsp_error  = 1'b0;
        sent       = 0;
        errors     = 0;
        checks     = 0;
        wr_idx     = 0;
        cf_idx     = 0;
        trap_idx   = 0;
        repeat (RESET_CYCLES) @(negedge g_clk);
        g_resetn = 1'b1;
        @(negedge g_clk);
        test_alu_mul();
        test_loads();
        test_control_flow();
        test_csr();
        test_traps();
        test_credits();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge g_clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped retiring",
                 TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+source
+incdir+bench
source/wb_pipe_pkg.sv
source/wb_sys_pkg.sv
source/load_align.sv
source/gpr_file.sv
source/csr_unit.sv
source/wb_ctrl.sv
source/wb_top.sv
bench/wb_tb.sv

// ==== Makefile ====
# Verilator build and run for the writeback stage testbench

VERILATOR ?= verilator
TOP       ?= wb_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
